// ==== tb.f ====
+incdir+rtl
rtl/adpcmb_pkg.sv
rtl/adpcmb_cnt.sv
rtl/adpcmb_decoder.sv
rtl/adpcmb_gain.sv
rtl/adpcmb_drv.sv
verification/tb_adpcmb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_adpcmb
FILELIST   := tb.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tb_adpcmb.sv ====
// Testbench for the ADPCM-B channel: clock, reset, sample memory, reference model and tests
`timescale 1ns/1ps
`include "adpcmb_defines.svh"

module tb_adpcmb import adpcmb_pkg::*; ();

    localparam int LEN_RESET  = 10;
    localparam int LEN_WALK   = 450;   // 64 reads at one per strobe
    localparam int LEN_PITCH  = 260;   // 8 reads at one per four strobes
    localparam int LEN_END    = 3200;  // Whole 512-nibble block plus idle time
    localparam int LEN_REPEAT = 3300;
    localparam int LEN_DECODE = 900;
    localparam int LEN_PAN    = 320;
    localparam int CYCLE_LIMIT = (LEN_RESET + LEN_WALK + LEN_PITCH + LEN_END + LEN_REPEAT
                                  + LEN_DECODE + LEN_PAN) * 3 / 2;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       cen;
    logic       cen55 = 1'b0;
    logic       on, rep, clr, clr_flag;
    logic [1:0] pan;
    raddr_t     astart, aend;
    logic [15:0] delta_n;
    level_t     level;
    logic [7:0] data;
    logic       flag, roe_n;
    maddr_t     addr;
    pcm_t       pcm_l, pcm_r;

    logic [7:0]  mem [0:65535];     // 64 KB sample memory
    logic [31:0] lfsr_state;
    int          cen_div = 0;
    int          cycles = 0;
    int          err_count = 0;
    int          errs_at_start = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    // Reference model state
    int          mdl_x, mdl_step;   // Predicted sample and step size
    int          exp_l, exp_r;
    logic        chk_out, exp_flag, playing, ended, rd_pending, on_prev, on_rise_m;
    logic [15:0] mdl_acc;
    logic [16:0] acc_sum;
    logic [24:0] next_rd, start_nib, end_nib; // Nibble positions
    logic [7:0]  byte_v;
    logic [3:0]  nib_q [$];         // Nibbles read but not yet decoded
    int          rd_count, strobe_count, since_rd;
    logic        have_prev_rd, pitch_chk;
    logic        hit_x_max, hit_x_min, hit_step_max, hit_step_min;

    always #20 clk = ~clk;          // 40 ns period

    assign data = mem[addr[15:0]];  // Combinational memory answer

    adpcmb_drv dut_i (
        .clk(clk), .rst_n(rst_n), .cen(cen), .cen55(cen55),
        .on(on), .rep(rep), .clr(clr), .clr_flag(clr_flag), .pan(pan),
        .astart(astart), .aend(aend), .delta_n(delta_n), .level(level), .data(data),
        .flag(flag), .addr(addr), .roe_n(roe_n), .pcm_l(pcm_l), .pcm_r(pcm_r)
    );

    // Output rate strobe, one clk in six
    always @(posedge clk) begin
        #2;
        if (cen_div == 5) begin
            cen_div = 0;
            cen55   = 1'b1;
        end else begin
            cen_div = cen_div + 1;
            cen55   = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d clock cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic value_error(input string msg);
        err_count = err_count + 1;
        $display("[ERROR] %0t %s", $time, msg);
    endtask

    task automatic note_failure(input string msg);
        err_count = err_count + 1;
        $display("%s", msg);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // Galois, right shift
    endfunction

    function automatic int step_factor(input int m);
        case (m)
            4:       return 77;
            5:       return 102;
            6:       return 128;
            7:       return 153;
            default: return 57;
        endcase
    endfunction

    function automatic int scale(input int x, input int lvl);
        return (x * (lvl + 1)) >>> 8;
    endfunction

    // One ADPCM-B step on the model, with clamp tracking
    task automatic decode_nibble(input logic [3:0] n);
        int m;
        int diff;
        int x;
        int st;
        m    = int'(n[2:0]);
        diff = ((2 * m + 1) * mdl_step) / 8;
        x    = n[3] ? mdl_x - diff : mdl_x + diff;
        if (x > 32767) begin
            x = 32767;
            hit_x_max = 1'b1;
        end else if (x < -32768) begin
            x = -32768;
            hit_x_min = 1'b1;
        end
        st = mdl_step * step_factor(m) / 64;
        if (st > int'(`ADPCMB_STEP_MAX)) begin
            st = int'(`ADPCMB_STEP_MAX);
            hit_step_max = 1'b1;
        end else if (st < int'(`ADPCMB_STEP_MIN)) begin
            st = int'(`ADPCMB_STEP_MIN);
            hit_step_min = 1'b1;
        end
        mdl_x    = x;
        mdl_step = st;
    endtask

    // Random fill, then a block at 0x200 that drives both clamps
    task automatic fill_memory();
        logic [7:0] b;
        lfsr_state = 32'h0ab59385;
        for (int a = 0; a < 65536; a++) begin
            for (int i = 0; i < 8; i++) begin
                b[i]       = lfsr_state[0];   // One step per bit
                lfsr_state = lfsr_next(lfsr_state);
            end
            mem[16'(a)] = b;
        end
        for (int a = 'h200; a < 'h210; a++) mem[16'(a)] = 8'h77; // Step and sample up
        for (int a = 'h210; a < 'h220; a++) mem[16'(a)] = 8'hff; // Sample down
        for (int a = 'h220; a < 'h240; a++) mem[16'(a)] = 8'h80; // Step shrinks to floor
    endtask

    // Reference model and checks, sampled on the rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            mdl_x = 0;
            mdl_step = int'(`ADPCMB_STEP_INIT);
            exp_flag = 1'b0;
            playing = 1'b0;
            ended = 1'b0;
            rd_pending = 1'b0;
            chk_out = 1'b0;
            on_prev = 1'b0;
            mdl_acc = '0;
            next_rd = '0;
            since_rd = 0;
            have_prev_rd = 1'b0;
            nib_q.delete();
        end else begin
            if (chk_out) begin                     // Gain result of the last strobe
                assert (int'(pcm_l) == exp_l)
                    else value_error($sformatf("pcm_l is %0d, expected %0d", pcm_l, exp_l));
                assert (int'(pcm_r) == exp_r)
                    else value_error($sformatf("pcm_r is %0d, expected %0d", pcm_r, exp_r));
            end
            chk_out = 1'b0;
            assert (flag == exp_flag)
                else value_error($sformatf("flag is %0b, expected %0b", flag, exp_flag));
            if (!roe_n) begin
                assert (rd_pending) else note_failure("memory read without a pitch carry");
                assert ({addr, dut_i.nibble_sel} == next_rd)
                    else value_error($sformatf("read at %h nibble %0b, expected %h nibble %0b",
                                               addr, dut_i.nibble_sel, next_rd[24:1], next_rd[0]));
                if (pitch_chk && have_prev_rd) begin
                    assert (since_rd == 65536 / int'(delta_n))
                        else value_error($sformatf("%0d strobes between reads", since_rd));
                end
                byte_v = mem[next_rd[16:1]];
                nib_q.push_back(next_rd[0] ? byte_v[3:0] : byte_v[7:4]); // Upper half first
                rd_pending   = 1'b0;
                rd_count     = rd_count + 1;
                since_rd     = 0;
                have_prev_rd = 1'b1;
                if (next_rd == end_nib) begin
                    next_rd = start_nib;
                    ended   = !rep;                // Without repeat the next carry ends
                end else begin
                    next_rd = next_rd + 25'd1;
                end
            end
            if (clr_flag) exp_flag = 1'b0;
            on_rise_m = on && !on_prev;
            if (cen55) begin
                assert (!rd_pending) else note_failure("expected memory read did not happen");
                strobe_count = strobe_count + 1;
                since_rd     = since_rd + 1;
                exp_l   = pan[1] ? scale(mdl_x, int'(level)) : 0;
                exp_r   = pan[0] ? scale(mdl_x, int'(level)) : 0;
                chk_out = 1'b1;
            end
            if (on_rise_m) begin
                mdl_x    = 0;
                mdl_step = int'(`ADPCMB_STEP_INIT);
            end else if (cen55 && nib_q.size() > 0) begin
                decode_nibble(nib_q.pop_front());
            end
            if (clr || !on) begin
                playing = 1'b0;
            end else if (on_rise_m) begin
                playing      = 1'b1;
                mdl_acc      = '0;
                start_nib    = 25'(astart) * 25'd512;                   // Two nibbles per byte
                end_nib      = (25'(aend) * 25'd256 + 25'd255) * 25'd2 + 25'd1; // Last low nibble
                next_rd      = start_nib;
                ended        = 1'b0;
                have_prev_rd = 1'b0;
            end else if (playing && cen55) begin
                acc_sum = {1'b0, mdl_acc} + {1'b0, delta_n};
                mdl_acc = acc_sum[15:0];
                if (acc_sum[16]) begin
                    if (ended) begin
                        playing  = 1'b0;
                        exp_flag = 1'b1;
                    end else begin
                        rd_pending = 1'b1;
                    end
                end
            end
            on_prev = on;
        end
    end

    roe_single: assert property (@(posedge clk) disable iff (!rst_n) !roe_n |=> roe_n)
        else note_failure("roe_n stayed low for more than one clock");

    task automatic at_drive_point();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_reads(input int n);
        int target;
        target = rd_count + n;
        while (rd_count < target) @(posedge clk);
    endtask

    task automatic wait_strobes(input int n);
        int target;
        target = strobe_count + n;
        while (strobe_count < target) @(posedge clk);
    endtask

    task automatic key_on(input raddr_t st, input raddr_t en, input logic [15:0] dn,
                          input logic rp);
        at_drive_point();
        astart  = st;
        aend    = en;
        delta_n = dn;
        rep     = rp;
        on      = 1'b1;
    endtask

    task automatic key_off();
        at_drive_point();
        on = 1'b0;
        wait_strobes(3);                           // Latch drains before the next key-on
    endtask

    task automatic end_test(input string name);
        if (err_count == errs_at_start) begin
            tests_passed = tests_passed + 1;
            $display("test %s passed", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s failed with %0d errors", name, err_count - errs_at_start);
        end
        errs_at_start = err_count;
    endtask

    initial begin
        pcm_t hold_l;
        pcm_t hold_r;
        int   snap;
        cen      = 1'b1;
        on       = 1'b0;
        rep      = 1'b0;
        clr      = 1'b0;
        clr_flag = 1'b0;
        pan      = 2'b11;
        astart   = '0;
        aend     = '0;
        delta_n  = '0;
        level    = 8'd255;
        rst_n = 1'b0;
        rd_count = 0;
        strobe_count = 0;
        pitch_chk = 1'b0;
        fill_memory();
        repeat (LEN_RESET) @(posedge clk);
        #2 rst_n = 1'b1;
        assert (roe_n && !flag && pcm_l == '0 && pcm_r == '0)
            else value_error("outputs not at their reset values");

        key_on(16'd1, 16'd1, 16'd65535, 1'b0);     // Address walk, one nibble per strobe
        wait_reads(64);
        key_off();
        end_test("address walk");

        key_on(16'd3, 16'd3, 16'd16384, 1'b0);     // Quarter rate
        pitch_chk = 1'b1;
        wait_reads(8);
        pitch_chk = 1'b0;
        key_off();
        end_test("pitch");

        key_on(16'd4, 16'd4, 16'd65535, 1'b0);
        while (!flag) @(posedge clk);
        wait_strobes(8);                           // Model rejects any further read
        at_drive_point();
        clr_flag = 1'b1;
        at_drive_point();
        clr_flag = 1'b0;
        at_drive_point();
        assert (!flag) else value_error("flag still set after clr_flag");
        key_off();
        end_test("end without repeat");

        key_on(16'd5, 16'd5, 16'd65535, 1'b1);     // 540 reads cross the end once
        wait_reads(540);
        key_off();
        end_test("repeat");

        at_drive_point();
        level = 8'd100;
        hit_x_max    = 1'b0;
        hit_x_min    = 1'b0;
        hit_step_max = 1'b0;
        hit_step_min = 1'b0;
        key_on(16'd2, 16'd2, 16'd65535, 1'b0);
        wait_reads(140);
        key_off();
        assert (hit_x_max && hit_x_min && hit_step_max && hit_step_min)
            else note_failure("decode data did not reach the sample and step clamps");
        end_test("decode and gain");

        at_drive_point();
        pan = 2'b10;
        key_on(16'd6, 16'd6, 16'd65535, 1'b0);
        wait_reads(16);
        at_drive_point();
        pan = 2'b01;
        wait_reads(16);
        at_drive_point();
        clr = 1'b1;                                // Channel reset stops the walk
        snap = rd_count;
        wait_strobes(3);
        hold_l = pcm_l;
        hold_r = pcm_r;
        wait_strobes(8);
        assert (rd_count <= snap + 1) else note_failure("reads continued after clr");
        assert (pcm_l == hold_l && pcm_r == hold_r)
            else value_error("outputs changed after clr");
        at_drive_point();
        clr = 1'b0;
        key_off();
        end_test("pan and stop");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (err_count == 0 && tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/adpcmb_drv.sv ====
// ADPCM-B channel top level with nibble latch and memory read strobe
`timescale 1ns/1ps
`include "adpcmb_defines.svh"

module adpcmb_drv import adpcmb_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cen,       // Chip rate, used elsewhere in the chip
    input  logic                     cen55,     // Output sample rate strobe
    input  logic                     on,        // Key-on
    input  logic                     rep,       // Repeat
    input  logic                     clr,       // Channel reset
    input  logic                     clr_flag,  // End flag clear pulse
    input  logic [1:0]               pan,       // Left/right enables
    input  raddr_t                   astart,
    input  raddr_t                   aend,
    input  logic [`ADPCMB_ACC_W-1:0] delta_n,   // Pitch
    input  level_t                   level,
    input  logic [7:0]               data,      // Sample memory byte
    output logic                     flag,
    output maddr_t                   addr,
    output logic                     roe_n,     // Memory read strobe
    output pcm_t                     pcm_l,
    output pcm_t                     pcm_r
);

    logic    nibble_sel;
    logic    adv;
    logic    nib_valid; // Latch full
    logic    nib_taken;
    nibble_t nib;
    pcm_t    pcm_dec;

    adpcmb_cnt u_cnt (
        .clk        (clk),
        .rst_n      (rst_n),
        .cen55      (cen55),
        .on         (on),
        .rep        (rep),
        .clr        (clr),
        .clr_flag   (clr_flag),
        .astart     (astart),
        .aend       (aend),
        .delta_n    (delta_n),
        .addr       (addr),
        .nibble_sel (nibble_sel),
        .adv        (adv),
        .flag       (flag)
    );

    // Read strobe follows adv by one cycle, valid level until the decoder takes it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            roe_n     <= 1'b1;
            nib_valid <= 1'b0;
        end else begin
            roe_n <= ~adv;
            if (!roe_n) begin
                nib_valid <= 1'b1;        // Fresh nibble in the latch
            end else if (nib_taken) begin
                nib_valid <= 1'b0;
            end
        end
    end

    // Nibble payload, upper half first
    always_ff @(posedge clk) begin
        if (!roe_n) begin
            nib <= nibble_sel ? data[3:0] : data[7:4];
        end
    end

    adpcmb_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen55     (cen55),
        .on        (on),
        .nib_valid (nib_valid),
        .nib       (nib),
        .pcm       (pcm_dec),
        .nib_taken (nib_taken)
    );

    adpcmb_gain u_gain (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen55  (cen55),
        .level  (level),
        .pan    (pan),
        .pcm_in (pcm_dec),
        .pcm_l  (pcm_l),
        .pcm_r  (pcm_r)
    );

endmodule

// ==== rtl/adpcmb_gain.sv ====
// ADPCM-B output level scaling and left/right pan registers at the output rate
`timescale 1ns/1ps

module adpcmb_gain import adpcmb_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen55,  // Output sample rate strobe
    input  level_t     level,  // 0 is quietest, 255 is unity
    input  logic [1:0] pan,    // Bit 1 left, bit 0 right
    input  pcm_t       pcm_in,
    output pcm_t       pcm_l,
    output pcm_t       pcm_r
);

    logic signed [9:0]  gain;   // level + 1, always positive
    logic signed [25:0] prod;
    pcm_t               scaled;

    assign gain   = $signed({1'b0, ({1'b0, level} + 9'd1)});
    assign prod   = pcm_in * gain;
    // Shift right by 8, upper bits are pure sign extension
    assign scaled = prod[23:8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcm_l <= '0;
            pcm_r <= '0;
        end else if (cen55) begin
            pcm_l <= pan[1] ? scaled : '0; // Muted side outputs silence
            pcm_r <= pan[0] ? scaled : '0;
        end
    end

endmodule

// ==== rtl/adpcmb_decoder.sv ====
// ADPCM-B step-size decoder with sample and step clamping and key-on reset
`timescale 1ns/1ps
`include "adpcmb_defines.svh"

module adpcmb_decoder import adpcmb_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cen55,     // Output sample rate strobe
    input  logic    on,        // Key-on level
    input  logic    nib_valid, // Latch holds an unused nibble
    input  nibble_t nib,
    output pcm_t    pcm,       // Predicted sample, held between updates
    output logic    nib_taken  // Nibble consumed this cycle
);

    logic               on_d;
    logic               on_rise;
    logic               update;
    logic [2:0]         mag;
    logic               sgn;
    step_t              step;
    logic [7:0]         factor;      // Step scale, 64 means unity
    logic [18:0]        diff_prod;   // (2m+1) * step
    logic [15:0]        diff;
    logic signed [17:0] x_sum;       // Unclamped new sample
    pcm_t               x_next;
    logic [22:0]        step_prod;   // step * factor
    logic [16:0]        step_scaled;
    step_t              step_next;

    assign on_rise   = on & ~on_d;
    assign update    = cen55 & nib_valid;
    assign nib_taken = update;
    assign mag       = nib[2:0];
    assign sgn       = nib[3];

    // Step adaptation table
    always_comb begin
        case (mag)
            3'd4:    factor = 8'd77;
            3'd5:    factor = 8'd102;
            3'd6:    factor = 8'd128;
            3'd7:    factor = 8'd153;
            default: factor = 8'd57;  // Small codes shrink the step
        endcase
    end

    // Difference and new sample
    always_comb begin
        diff_prod = 19'({mag, 1'b1}) * 19'(step);
        diff      = diff_prod[18:3];            // Divide by 8
        if (sgn) begin
            x_sum = $signed({{2{pcm[15]}}, pcm}) - $signed({2'b00, diff});
        end else begin
            x_sum = $signed({{2{pcm[15]}}, pcm}) + $signed({2'b00, diff});
        end
        if (x_sum > 18'sd32767) begin
            x_next = 16'sh7fff;                 // Positive saturation
        end else if (x_sum < -18'sd32768) begin
            x_next = 16'sh8000;                 // Negative saturation
        end else begin
            x_next = x_sum[15:0];
        end
    end

    // Next step size
    always_comb begin
        step_prod   = 23'(step) * 23'(factor);
        step_scaled = step_prod[22:6];          // Divide by 64
        if (step_scaled < {2'b00, `ADPCMB_STEP_MIN}) begin
            step_next = `ADPCMB_STEP_MIN;
        end else if (step_scaled > {2'b00, `ADPCMB_STEP_MAX}) begin
            step_next = `ADPCMB_STEP_MAX;
        end else begin
            step_next = step_scaled[14:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            on_d <= 1'b0;
            pcm  <= '0;
            step <= `ADPCMB_STEP_INIT;
        end else begin
            on_d <= on;
            if (on_rise) begin
                pcm  <= '0;                     // Fresh start on key-on
                step <= `ADPCMB_STEP_INIT;
            end else if (update) begin
                pcm  <= x_next;
                step <= step_next;
            end
        end
    end

endmodule

// ==== rtl/adpcmb_cnt.sv ====
// ADPCM-B pitch accumulator and nibble address counter with end, repeat and flag logic
`timescale 1ns/1ps
`include "adpcmb_defines.svh"

module adpcmb_cnt import adpcmb_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cen55,      // Output sample rate strobe
    input  logic                     on,         // Key-on level
    input  logic                     rep,        // Loop back to start at end
    input  logic                     clr,        // Channel reset level
    input  logic                     clr_flag,   // Clears the end flag
    input  raddr_t                   astart,
    input  raddr_t                   aend,
    input  logic [`ADPCMB_ACC_W-1:0] delta_n,    // Pitch step
    output maddr_t                   addr,
    output logic                     nibble_sel, // 0 picks the upper nibble
    output logic                     adv,        // New nibble position this cycle
    output logic                     flag        // Sticky end of sample
);

    localparam int POS_W = 25; // Byte address plus nibble bit

    cnt_state_e               state;
    logic [`ADPCMB_ACC_W-1:0] acc;        // Fractional phase
    logic [`ADPCMB_ACC_W:0]   acc_sum;    // Phase plus carry
    logic [POS_W-1:0]         pos;        // Current nibble position
    logic [POS_W-1:0]         start_pos;
    logic [POS_W-1:0]         end_pos;
    logic                     on_d;
    logic                     on_rise;
    logic                     first;      // Start nibble not read yet

    assign on_rise   = on & ~on_d;
    assign start_pos = {astart, 9'h000};           // astart * 512 nibbles
    assign end_pos   = {aend, 9'h1ff};             // Low nibble of aend*256+255
    assign acc_sum   = {1'b0, acc} + {1'b0, delta_n};

    // Byte address and nibble select come straight from the position register
    assign addr       = pos[POS_W-1:1];
    assign nibble_sel = pos[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            acc   <= '0;
            pos   <= '0;
            on_d  <= 1'b0;
            first <= 1'b0;
            adv   <= 1'b0;
            flag  <= 1'b0;
        end else begin
            on_d <= on;
            adv  <= 1'b0;                   // Single-cycle strobe by default
            if (clr_flag) begin
                flag <= 1'b0;
            end
            if (clr || !on) begin
                state <= IDLE;              // Reset or key-off stops the walk
                first <= 1'b0;
            end else if (on_rise) begin
                state <= PLAY;
                pos   <= start_pos;
                acc   <= '0;
                first <= 1'b1;              // First carry reads start itself
            end else if (state == PLAY && cen55) begin
                acc <= acc_sum[`ADPCMB_ACC_W-1:0];
                if (acc_sum[`ADPCMB_ACC_W]) begin
                    if (first) begin
                        first <= 1'b0;
                        adv   <= 1'b1;      // Position already at start
                    end else if (pos == end_pos) begin
                        if (rep) begin
                            pos <= start_pos; // Loop
                            adv <= 1'b1;
                        end else begin
                            state <= DONE;
                            flag  <= 1'b1;  // Host sees end of sample
                        end
                    end else begin
                        pos <= pos + 25'd1; // Next nibble
                        adv <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== rtl/adpcmb_pkg.sv ====
// ADPCM-B channel types: sample, nibble, address, step, level and counter states
package adpcmb_pkg;

    // Audio path
    typedef logic signed [15:0] pcm_t;    // Signed PCM sample
    typedef logic        [3:0]  nibble_t; // One ADPCM code
    typedef logic        [14:0] step_t;   // Decoder step size
    typedef logic        [7:0]  level_t;  // Output level

    // Memory side
    typedef logic [23:0] maddr_t; // Byte address into sample ROM
    typedef logic [15:0] raddr_t; // Register address, 256-byte units

    // Address counter FSM
    typedef enum logic [1:0] {
        IDLE, // Waiting for key-on
        PLAY, // Walking the sample
        DONE  // End reached, no repeat
    } cnt_state_e;

endpackage

// ==== rtl/adpcmb_defines.svh ====
// ADPCM-B decoder step limits, initial step and pitch accumulator width
`ifndef ADPCMB_DEFINES_SVH
`define ADPCMB_DEFINES_SVH

// Step size bounds, 15-bit unsigned
`define ADPCMB_STEP_MIN  15'd127    // Floor of the adaptive step
`define ADPCMB_STEP_MAX  15'd24576  // Ceiling of the adaptive step
`define ADPCMB_STEP_INIT 15'd127    // Step loaded on key-on

// Pitch accumulator, same width as delta-N
`define ADPCMB_ACC_W     16

`endif
